// File: fc_irq_subsystem.f
+incdir+tests
design/fc_irq_pkg.sv
design/fc_event_unit.sv
design/fc_apb_to_reg.sv
design/fc_clic.sv
design/fc_irq_subsystem.sv
tests/tb_fc_irq_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt subsystem testbench with Verilator.
# Exits non-zero when the build fails, the simulator fails, or the log
# reports a failing run.

cd "$(dirname "$0")" || exit 1

TOP=tb_fc_irq_subsystem
FILE_LIST=fc_irq_subsystem.f
BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f "$FILE_LIST" \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "no pass report found in $LOG"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: tests/tb_fc_irq_tasks.svh
// Interrupt subsystem testbench tasks
// APB masters for the event-unit and CLIC ports, the value check,
// event pushes and the core side of the interrupt handshake

`ifndef TB_FC_IRQ_TASKS_SVH
`define TB_FC_IRQ_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
    end
endtask

task automatic report_failure(input string what);
    err_count++;
    $display("error at %0t: %s", $time, what);
endtask

// Setup then access phase, outputs sampled in the middle of the access phase
task automatic eu_apb(input logic write, input logic [APB_AW-1:0] addr,
                      input logic [APB_DW-1:0] wdata,
                      output logic [APB_DW-1:0] rdata, output logic slverr);
    @(posedge clk_i);
    eu_psel_i    <= 1'b1;
    eu_penable_i <= 1'b0;
    eu_pwrite_i  <= write;
    eu_paddr_i   <= addr;
    eu_pwdata_i  <= wdata;
    @(posedge clk_i);
    eu_penable_i <= 1'b1;
    @(negedge clk_i);
    rdata  = eu_prdata_o;
    slverr = eu_pslverr_o;
    check_value("eu_pready_o", eu_pready_o, 1);
    @(posedge clk_i);
    eu_psel_i    <= 1'b0;
    eu_penable_i <= 1'b0;
endtask

task automatic clic_apb(input logic write, input logic [APB_AW-1:0] addr,
                        input logic [APB_DW-1:0] wdata,
                        output logic [APB_DW-1:0] rdata, output logic slverr);
    @(posedge clk_i);
    clic_psel_i    <= 1'b1;
    clic_penable_i <= 1'b0;
    clic_pwrite_i  <= write;
    clic_paddr_i   <= addr;
    clic_pwdata_i  <= wdata;
    @(posedge clk_i);
    clic_penable_i <= 1'b1;
    @(negedge clk_i);
    rdata  = clic_prdata_o;
    slverr = clic_pslverr_o;
    check_value("clic_pready_o", clic_pready_o, 1);
    @(posedge clk_i);
    clic_psel_i    <= 1'b0;
    clic_penable_i <= 1'b0;
endtask

task automatic clic_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] wdata);
    logic [APB_DW-1:0] rdata;
    logic              slverr;
    clic_apb(1'b1, addr, wdata, rdata, slverr);
    check_value("clic_pslverr_o", slverr, 0);
endtask

// Only used while the model FIFO has room, so ready must be high
task automatic push_event(input logic [EVENT_ID_W-1:0] id);
    @(posedge clk_i);
    event_valid_i <= 1'b1;
    event_data_i  <= id;
    @(negedge clk_i);
    check_value("event_ready_o", event_ready_o, fifo_m.size() != EU_DEPTH);
    @(posedge clk_i);
    event_valid_i <= 1'b0;
    fifo_m.push_back(id);
endtask

// Core side: wait for valid, hold off ready a random time, then acknowledge once
task automatic ack_irq(input int exp_id, input int exp_lvl, input int max_delay);
    int                  waits;
    int                  delay;
    logic [SRC_ID_W-1:0] id0;
    logic [LEVEL_W-1:0]  lvl0;
    waits = 0;
    @(negedge clk_i);
    while (!irq_valid_o && waits < IRQ_WAIT_LIMIT) begin
        @(negedge clk_i);
        waits++;
    end
    if (!irq_valid_o) begin
        report_failure("irq_valid_o never rose for an expected interrupt");
        return;
    end
    id0  = irq_id_o;
    lvl0 = irq_level_o;
    check_value("irq_id_o", id0, exp_id);
    check_value("irq_level_o", lvl0, exp_lvl);
    check_value("irq_level_o above thresh", lvl0 > thresh_m, 1);
    check_value("irq source enable", en_m[id0], 1);
    delay = rand_below(max_delay + 1);
    repeat (delay + 1) begin
        @(negedge clk_i);
        check_value("irq_valid_o", irq_valid_o, 1);
        check_value("irq_id_o", irq_id_o, id0);
        check_value("irq_level_o", irq_level_o, lvl0);
    end
    @(posedge clk_i);
    irq_ready_i <= 1'b1;
    @(posedge clk_i);
    irq_ready_i <= 1'b0;
    @(negedge clk_i);
    check_value("irq_valid_o after ack", irq_valid_o, 0);
endtask

`endif

// File: tests/tb_fc_irq_subsystem.sv
// Interrupt subsystem testbench
// Random stimulus from a fixed seed, checked against a reference model of
// the event FIFO, the CLIC configuration, pending bits and the winner rule

`timescale 1ns/10ps

module tb_fc_irq_subsystem
    import fc_irq_pkg::*;
();

    localparam int CYCLE_LIMIT    = 5 * 2000;
    localparam int IRQ_WAIT_LIMIT = 50;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  event_valid_i;
    logic [EVENT_ID_W-1:0] event_data_i;
    logic                  event_ready_o;
    logic [N_SRC-2:0]      events_i;
    logic                  eu_psel_i;
    logic                  eu_penable_i;
    logic                  eu_pwrite_i;
    logic [APB_AW-1:0]     eu_paddr_i;
    logic [APB_DW-1:0]     eu_pwdata_i;
    logic [APB_DW-1:0]     eu_prdata_o;
    logic                  eu_pready_o;
    logic                  eu_pslverr_o;
    logic                  clic_psel_i;
    logic                  clic_penable_i;
    logic                  clic_pwrite_i;
    logic [APB_AW-1:0]     clic_paddr_i;
    logic [APB_DW-1:0]     clic_pwdata_i;
    logic [APB_DW-1:0]     clic_prdata_o;
    logic                  clic_pready_o;
    logic                  clic_pslverr_o;
    logic                  irq_valid_o;
    logic [SRC_ID_W-1:0]   irq_id_o;
    logic [LEVEL_W-1:0]    irq_level_o;
    logic                  irq_ready_i;

    integer seed;
    int     check_count;
    int     err_count;
    int     test_err_base;
    int     cycle_count;

    //******************************
    // Reference model state
    //******************************
    logic                  en_m   [N_SRC];
    logic                  mode_m [N_SRC];
    logic [LEVEL_W-1:0]    lvl_m  [N_SRC];
    logic                  pend_m [N_SRC];
    logic [LEVEL_W-1:0]    thresh_m;
    logic [EVENT_ID_W-1:0] fifo_m [$];

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    `include "tb_fc_irq_tasks.svh"

    fc_irq_subsystem u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    // Highest level wins, strict compare keeps the lowest id on a tie
    function automatic int model_winner();
        int best;
        best = -1;
        for (int s = 0; s < N_SRC; s++) begin
            if (en_m[s] && pend_m[s] && (lvl_m[s] > thresh_m)) begin
                if (best < 0 || lvl_m[s] > lvl_m[best]) begin
                    best = s;
                end
            end
        end
        return best;
    endfunction

    // Direct lines skip the SoC event slot
    function automatic int line_to_src(input int j);
        return (j < SOC_EVENT_SRC) ? j : j + 1;
    endfunction

    task automatic set_cfg(input int s, input logic [APB_DW-1:0] wdata);
        clic_write(APB_AW'(4 * s), wdata);
        en_m[s]   = wdata[0];
        mode_m[s] = wdata[1];
        lvl_m[s]  = wdata[15:8];
    endtask

    task automatic set_thresh(input logic [LEVEL_W-1:0] t);
        clic_write(CLIC_THRESH_OFFS, {24'b0, t});
        thresh_m = t;
    endtask

    task automatic read_cfg_check(input int s);
        logic [APB_DW-1:0] rdata;
        logic              slverr;
        clic_apb(1'b0, APB_AW'(4 * s), '0, rdata, slverr);
        check_value("CLIC source config", rdata,
                    {15'b0, pend_m[s], lvl_m[s], 6'b0, mode_m[s], en_m[s]});
        check_value("clic_pslverr_o", slverr, 0);
    endtask

    task automatic pop_check();
        logic [APB_DW-1:0]     rdata;
        logic                  slverr;
        logic [EVENT_ID_W-1:0] exp;
        exp = fifo_m.pop_front();
        eu_apb(1'b0, EU_DATA, '0, rdata, slverr);
        check_value("EU_DATA", rdata, {24'b0, exp});
        check_value("eu_pslverr_o", slverr, 0);
    endtask

    task automatic pulse_lines(input logic [N_SRC-2:0] mask);
        @(posedge clk_i);
        events_i <= mask;
        @(posedge clk_i);
        events_i <= '0;
        for (int j = 0; j < N_SRC - 1; j++) begin
            if (mask[j]) begin
                pend_m[line_to_src(j)] = 1'b1;
            end
        end
    endtask

    // Acknowledge every interrupt the model expects, then expect silence
    task automatic drain_irqs(input int max_delay);
        int w;
        w = model_winner();
        while (w >= 0) begin
            ack_irq(w, lvl_m[w], max_delay);
            pend_m[w] = 1'b0;
            w = model_winner();
        end
        repeat (6) begin
            @(negedge clk_i);
            check_value("irq_valid_o", irq_valid_o, 0);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d errors", name,
                 (err_count == test_err_base) ? "pass" : "fail", err_count - test_err_base);
        test_err_base = err_count;
    endtask

    //******************************
    // Tests
    //******************************
    task automatic test_registers();
        logic [APB_DW-1:0] rdata;
        logic              slverr;
        logic [APB_DW-1:0] wdata;
        int                idx;
        @(negedge clk_i);
        check_value("irq_valid_o", irq_valid_o, 0);
        check_value("event_ready_o", event_ready_o, 1);
        check_value("eu_pslverr_o", eu_pslverr_o, 0);
        check_value("clic_pslverr_o", clic_pslverr_o, 0);
        for (int s = 0; s < N_SRC; s++) begin
            read_cfg_check(s);
        end
        repeat (24) begin
            idx   = rand_below(N_SRC + 1);
            wdata = rand_word();
            if (idx == N_SRC) begin
                set_thresh(wdata[7:0]);
                clic_apb(1'b0, CLIC_THRESH_OFFS, '0, rdata, slverr);
                check_value("CLIC THRESH", rdata, {24'b0, thresh_m});
            end else begin
                set_cfg(idx, wdata);
                read_cfg_check(idx);
            end
        end
        clic_apb(1'b0, 12'h200, '0, rdata, slverr);
        check_value("clic_pslverr_o unmapped", slverr, 1);
        clic_apb(1'b1, 12'h02A, rand_word(), rdata, slverr);
        check_value("clic_pslverr_o misaligned", slverr, 1);
        eu_apb(1'b1, EU_STATUS, rand_word(), rdata, slverr);
        check_value("eu_pslverr_o write", slverr, 1);
        eu_apb(1'b0, 12'h008, '0, rdata, slverr);
        check_value("eu_pslverr_o unmapped", slverr, 1);
        set_thresh(8'h00);
        for (int s = 0; s < N_SRC; s++) begin
            set_cfg(s, '0);
        end
        end_test("register access");
    endtask

    task automatic test_event_fifo();
        logic [APB_DW-1:0]     rdata;
        logic                  slverr;
        logic [EVENT_ID_W-1:0] id;
        int                    n;
        for (int round = 0; round < 8; round++) begin
            // Every other round fills the FIFO up to its depth
            n = (round % 2 == 0) ? EU_DEPTH : 1 + rand_below(EU_DEPTH);
            repeat (n) begin
                repeat (rand_below(4)) @(posedge clk_i);
                push_event(8'(rand_word()));
            end
            eu_apb(1'b0, EU_STATUS, '0, rdata, slverr);
            check_value("EU_STATUS", rdata, fifo_m.size());
            if (fifo_m.size() == EU_DEPTH) begin
                // Push against a full FIFO is held until a pop frees a slot
                id = 8'(rand_word());
                @(posedge clk_i);
                event_valid_i <= 1'b1;
                event_data_i  <= id;
                repeat (3) begin
                    @(negedge clk_i);
                    check_value("event_ready_o", event_ready_o, 0);
                end
                pop_check();
                @(negedge clk_i);
                check_value("event_ready_o", event_ready_o, 1);
                @(posedge clk_i);
                event_valid_i <= 1'b0;
                fifo_m.push_back(id);
            end
            while (fifo_m.size() > 0) begin
                pop_check();
            end
            eu_apb(1'b0, EU_DATA, '0, rdata, slverr);
            check_value("EU_DATA empty", rdata, 0);
            check_value("eu_pslverr_o", slverr, 0);
        end
        end_test("event FIFO order and back-pressure");
    endtask

    task automatic test_edge_priority();
        logic [APB_DW-1:0] w;
        repeat (6) begin
            // Nothing can win while the sources are reconfigured
            set_thresh(8'hFF);
            for (int s = 0; s < N_SRC; s++) begin
                if (s == SOC_EVENT_SRC) begin
                    set_cfg(s, '0);
                end else begin
                    set_cfg(s, {16'b0, 8'(rand_below(256)), 6'b0, 1'b0, rand_below(4) != 0});
                end
            end
            w = rand_word();
            pulse_lines(w[N_SRC-2:0]);
            set_thresh(8'(rand_below(128)));
            drain_irqs(3);
        end
        end_test("edge interrupts and priority");
    endtask

    task automatic test_handshake();
        logic [N_SRC-2:0] mask;
        set_thresh(8'h00);
        drain_irqs(12);
        repeat (10) begin
            mask = '0;
            mask[rand_below(N_SRC - 1)] = 1'b1;
            mask[rand_below(N_SRC - 1)] = 1'b1;
            pulse_lines(mask);
            drain_irqs(12);
        end
        end_test("handshake stability");
    endtask

    task automatic test_soc_level();
        logic [APB_DW-1:0] rdata;
        logic              slverr;
        set_thresh(8'hFF);
        for (int s = 0; s < N_SRC; s++) begin
            set_cfg(s, (s == SOC_EVENT_SRC) ? 32'h0000_8003 : 32'h0);
        end
        set_thresh(8'h10);
        push_event(8'(rand_word()));
        repeat (3) begin
            ack_irq(SOC_EVENT_SRC, 8'h80, 4);
        end
        // Next presentation is latched before the pop lands
        pop_check();
        eu_apb(1'b0, EU_STATUS, '0, rdata, slverr);
        check_value("EU_STATUS", rdata, 0);
        ack_irq(SOC_EVENT_SRC, 8'h80, 2);
        repeat (10) begin
            @(negedge clk_i);
            check_value("irq_valid_o", irq_valid_o, 0);
        end
        end_test("level-mode SoC event path");
    endtask

    initial begin
        seed          = 7345;
        check_count   = 0;
        err_count     = 0;
        test_err_base = 0;
        thresh_m      = '0;
        for (int s = 0; s < N_SRC; s++) begin
            en_m[s]   = 1'b0;
            mode_m[s] = 1'b0;
            lvl_m[s]  = '0;
            pend_m[s] = 1'b0;
        end
        rst_n_i        = 1'b0;
        event_valid_i  = 1'b0;
        event_data_i   = '0;
        events_i       = '0;
        eu_psel_i      = 1'b0;
        eu_penable_i   = 1'b0;
        eu_pwrite_i    = 1'b0;
        eu_paddr_i     = '0;
        eu_pwdata_i    = '0;
        clic_psel_i    = 1'b0;
        clic_penable_i = 1'b0;
        clic_pwrite_i  = 1'b0;
        clic_paddr_i   = '0;
        clic_pwdata_i  = '0;
        irq_ready_i    = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        test_registers();
        test_event_fifo();
        test_edge_priority();
        test_handshake();
        test_soc_level();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/fc_irq_subsystem.sv
// Interrupt subsystem top level
// Connects the SoC event unit, the CLIC register bridge and the CLIC,
// and merges the event-unit level into the direct interrupt lines

`timescale 1ns/10ps

module fc_irq_subsystem
    import fc_irq_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  event_valid_i,
    input  logic [EVENT_ID_W-1:0] event_data_i,
    output logic                  event_ready_o,
    input  logic [N_SRC-2:0]      events_i,
    input  logic                  eu_psel_i,
    input  logic                  eu_penable_i,
    input  logic                  eu_pwrite_i,
    input  logic [APB_AW-1:0]     eu_paddr_i,
    input  logic [APB_DW-1:0]     eu_pwdata_i,
    output logic [APB_DW-1:0]     eu_prdata_o,
    output logic                  eu_pready_o,
    output logic                  eu_pslverr_o,
    input  logic                  clic_psel_i,
    input  logic                  clic_penable_i,
    input  logic                  clic_pwrite_i,
    input  logic [APB_AW-1:0]     clic_paddr_i,
    input  logic [APB_DW-1:0]     clic_pwdata_i,
    output logic [APB_DW-1:0]     clic_prdata_o,
    output logic                  clic_pready_o,
    output logic                  clic_pslverr_o,
    output logic                  irq_valid_o,
    output logic [SRC_ID_W-1:0]   irq_id_o,
    output logic [LEVEL_W-1:0]    irq_level_o,
    input  logic                  irq_ready_i
);

    logic              soc_event_int;
    logic [N_SRC-1:0]  intr_src;
    logic              reg_valid;
    logic              reg_write;
    logic [APB_AW-1:0] reg_addr;
    logic [APB_DW-1:0] reg_wdata;
    logic [APB_DW-1:0] reg_rdata;
    logic              reg_error;
    logic              reg_ready;

    // SoC event level sits at its fixed slot, direct lines shift around it
    assign intr_src = {events_i[N_SRC-2:SOC_EVENT_SRC], soc_event_int,
                       events_i[SOC_EVENT_SRC-1:0]};

    fc_event_unit u_event_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .event_ready_o (event_ready_o),
        .psel_i        (eu_psel_i),
        .penable_i     (eu_penable_i),
        .pwrite_i      (eu_pwrite_i),
        .paddr_i       (eu_paddr_i),
        .pwdata_i      (eu_pwdata_i),
        .prdata_o      (eu_prdata_o),
        .pready_o      (eu_pready_o),
        .pslverr_o     (eu_pslverr_o),
        .int_lvl_o     (soc_event_int)
    );

    fc_apb_to_reg u_apb_to_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (clic_psel_i),
        .penable_i   (clic_penable_i),
        .pwrite_i    (clic_pwrite_i),
        .paddr_i     (clic_paddr_i),
        .pwdata_i    (clic_pwdata_i),
        .prdata_o    (clic_prdata_o),
        .pready_o    (clic_pready_o),
        .pslverr_o   (clic_pslverr_o),
        .reg_valid_o (reg_valid),
        .reg_write_o (reg_write),
        .reg_addr_o  (reg_addr),
        .reg_wdata_o (reg_wdata),
        .reg_rdata_i (reg_rdata),
        .reg_error_i (reg_error),
        .reg_ready_i (reg_ready)
    );

    fc_clic u_clic (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_valid_i (reg_valid),
        .reg_write_i (reg_write),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .reg_error_o (reg_error),
        .reg_ready_o (reg_ready),
        .intr_src_i  (intr_src),
        .irq_valid_o (irq_valid_o),
        .irq_id_o    (irq_id_o),
        .irq_level_o (irq_level_o),
        .irq_ready_i (irq_ready_i)
    );

endmodule

// File: design/fc_clic.sv
// Core-local interrupt controller
// Per-source enable, trigger mode and level, a global threshold, pending
// tracking for edge and level sources, a priority tree and a registered
// valid/ready handshake towards the core

`timescale 1ns/10ps

module fc_clic
    import fc_irq_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                reg_valid_i,
    input  logic                reg_write_i,
    input  logic [APB_AW-1:0]   reg_addr_i,
    input  logic [APB_DW-1:0]   reg_wdata_i,
    output logic [APB_DW-1:0]   reg_rdata_o,
    output logic                reg_error_o,
    output logic                reg_ready_o,
    input  logic [N_SRC-1:0]    intr_src_i,
    output logic                irq_valid_o,
    output logic [SRC_ID_W-1:0] irq_id_o,
    output logic [LEVEL_W-1:0]  irq_level_o,
    input  logic                irq_ready_i
);

    localparam int unsigned TREE_N = 2 * N_SRC - 1;

    logic [N_SRC-1:0]    cfg_en_q;
    logic [N_SRC-1:0]    cfg_mode_q;
    logic [LEVEL_W-1:0]  cfg_lvl_q [N_SRC];
    logic [LEVEL_W-1:0]  thresh_q;
    logic [N_SRC-1:0]    src_q;
    logic [N_SRC-1:0]    pending_q;
    logic [N_SRC-1:0]    pending_d;
    logic [N_SRC-1:0]    ack_clr;
    logic [N_SRC-1:0]    eligible;
    clic_reg_e           reg_kind;
    logic [SRC_ID_W-1:0] reg_idx;
    logic                reg_wr;
    logic                irq_ack;
    logic                tree_vld [TREE_N];
    logic [LEVEL_W-1:0]  tree_lvl [TREE_N];
    logic [SRC_ID_W-1:0] tree_id  [TREE_N];
    logic                valid_q;
    logic [SRC_ID_W-1:0] id_q;
    logic [LEVEL_W-1:0]  level_q;

    //******************************
    // Register access
    //******************************
    always_comb begin
        reg_idx = reg_addr_i[2 +: SRC_ID_W];
        if ((reg_addr_i < APB_AW'(4 * N_SRC)) && (reg_addr_i[1:0] == 2'b00)) begin
            reg_kind = CLIC_SRC_CFG;
        end else if (reg_addr_i == CLIC_THRESH_OFFS) begin
            reg_kind = CLIC_THRESH;
        end else begin
            reg_kind = CLIC_UNMAPPED;
        end
    end

    assign reg_ready_o = 1'b1;
    assign reg_error_o = reg_valid_i & (reg_kind == CLIC_UNMAPPED);
    assign reg_wr      = reg_valid_i & reg_write_i;

    always_comb begin
        reg_rdata_o = '0;
        case (reg_kind)
            CLIC_SRC_CFG: begin
                reg_rdata_o[CFG_EN_BIT]                  = cfg_en_q[reg_idx];
                reg_rdata_o[CFG_MODE_BIT]                = cfg_mode_q[reg_idx];
                reg_rdata_o[CFG_LVL_LSB +: LEVEL_W]      = cfg_lvl_q[reg_idx];
                reg_rdata_o[CFG_PEND_BIT]                = pending_q[reg_idx];
            end
            CLIC_THRESH: reg_rdata_o[LEVEL_W-1:0] = thresh_q;
            default: reg_rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_en_q   <= '0;
            cfg_mode_q <= '0;
            thresh_q   <= '0;
            for (int i = 0; i < N_SRC; i++) begin
                cfg_lvl_q[i] <= '0;
            end
        end else if (reg_wr) begin
            case (reg_kind)
                CLIC_SRC_CFG: begin
                    cfg_en_q[reg_idx]   <= reg_wdata_i[CFG_EN_BIT];
                    cfg_mode_q[reg_idx] <= reg_wdata_i[CFG_MODE_BIT];
                    cfg_lvl_q[reg_idx]  <= reg_wdata_i[CFG_LVL_LSB +: LEVEL_W];
                end
                CLIC_THRESH: thresh_q <= reg_wdata_i[LEVEL_W-1:0];
                default: begin
                end
            endcase
        end
    end

    //******************************
    // Pending tracking
    //******************************
    assign irq_ack = valid_q & irq_ready_i;

    // Only edge sources are cleared by the core
    always_comb begin
        ack_clr = '0;
        if (irq_ack && !cfg_mode_q[id_q]) begin
            ack_clr[id_q] = 1'b1;
        end
    end

    // Level sources follow the input, a new rising edge beats the clear
    assign pending_d = (cfg_mode_q & intr_src_i)
                     | (~cfg_mode_q & ((pending_q & ~ack_clr) | (intr_src_i & ~src_q)));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            src_q     <= '0;
            pending_q <= '0;
        end else begin
            src_q     <= intr_src_i;
            pending_q <= pending_d;
        end
    end

    //******************************
    // Priority tree
    //******************************
    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            eligible[i] = cfg_en_q[i] & pending_q[i] & (cfg_lvl_q[i] > thresh_q);
        end
    end

    // Heap layout, leaves at N_SRC-1 and up, left child holds lower ids
    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            tree_vld[N_SRC-1+i] = eligible[i];
            tree_lvl[N_SRC-1+i] = cfg_lvl_q[i];
            tree_id[N_SRC-1+i]  = SRC_ID_W'(i);
        end
        for (int n = N_SRC - 2; n >= 0; n--) begin
            if (tree_vld[2*n+1] &&
                (!tree_vld[2*n+2] || (tree_lvl[2*n+1] >= tree_lvl[2*n+2]))) begin
                tree_vld[n] = 1'b1;
                tree_lvl[n] = tree_lvl[2*n+1];
                tree_id[n]  = tree_id[2*n+1];
            end else begin
                tree_vld[n] = tree_vld[2*n+2];
                tree_lvl[n] = tree_lvl[2*n+2];
                tree_id[n]  = tree_id[2*n+2];
            end
        end
    end

    //******************************
    // Core handshake
    //******************************
    // Valid drops for one cycle after every acknowledge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (irq_ack) begin
            valid_q <= 1'b0;
        end else if (!valid_q) begin
            valid_q <= tree_vld[0];
        end
    end

    // Selection is frozen while presented
    always_ff @(posedge clk_i) begin
        if (!valid_q) begin
            id_q    <= tree_id[0];
            level_q <= tree_lvl[0];
        end
    end

    assign irq_valid_o = valid_q;
    assign irq_id_o    = id_q;
    assign irq_level_o = level_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_valid_o && !irq_ready_i |=>
            irq_valid_o && $stable(irq_id_o) && $stable(irq_level_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(irq_valid_o) |-> cfg_en_q[irq_id_o]);

endmodule

// File: design/fc_apb_to_reg.sv
// APB slave to register bus bridge
// Turns each APB transfer into exactly one register request and returns
// the register response as read data, ready and error

`timescale 1ns/10ps

module fc_apb_to_reg
    import fc_irq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              reg_valid_o,
    output logic              reg_write_o,
    output logic [APB_AW-1:0] reg_addr_o,
    output logic [APB_DW-1:0] reg_wdata_o,
    input  logic [APB_DW-1:0] reg_rdata_i,
    input  logic              reg_error_i,
    input  logic              reg_ready_i
);

    // Set once the current access phase has been served
    logic done_q;

    assign reg_valid_o = psel_i & penable_i & ~done_q;
    assign reg_write_o = pwrite_i;
    assign reg_addr_o  = paddr_i;
    assign reg_wdata_o = pwdata_i;

    assign prdata_o  = reg_rdata_i;
    assign pready_o  = reg_ready_i;
    assign pslverr_o = reg_error_i;

    // Cleared when the master leaves the access phase
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (!(psel_i && penable_i)) begin
            done_q <= 1'b0;
        end else if (reg_valid_o && reg_ready_i) begin
            done_q <= 1'b1;
        end
    end

    // Address from setup holds through the access phase
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i && penable_i |-> $stable(paddr_i));

endmodule

// File: design/fc_event_unit.sv
// SoC event unit
// Queues incoming event ids in a small circular FIFO and raises a level
// interrupt while the queue holds anything. Software pops ids over APB.

`timescale 1ns/10ps

module fc_event_unit
    import fc_irq_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  event_valid_i,
    input  logic [EVENT_ID_W-1:0] event_data_i,
    output logic                  event_ready_o,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_AW-1:0]     paddr_i,
    input  logic [APB_DW-1:0]     pwdata_i,
    output logic [APB_DW-1:0]     prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  int_lvl_o
);

    logic [EVENT_ID_W-1:0] fifo_mem [EU_DEPTH];
    logic [EU_PTR_W-1:0]   wr_ptr_q;
    logic [EU_PTR_W-1:0]   rd_ptr_q;
    logic [EU_CNT_W-1:0]   count_q;
    logic                  apb_access;
    logic                  push;
    logic                  pop;
    logic                  not_empty;

    assign not_empty     = (count_q != '0);
    assign event_ready_o = (count_q != EU_CNT_W'(EU_DEPTH));
    assign int_lvl_o     = not_empty;
    assign push          = event_valid_i & event_ready_o;

    // No wait states on this port
    assign apb_access = psel_i & penable_i;
    assign pready_o   = 1'b1;
    assign pop        = apb_access & ~pwrite_i & (paddr_i == EU_DATA) & not_empty;

    always_comb begin
        prdata_o  = '0;
        pslverr_o = apb_access & pwrite_i;
        case (paddr_i)
            EU_DATA: begin
                if (not_empty) begin
                    prdata_o = APB_DW'(fifo_mem[rd_ptr_q]);
                end
            end
            EU_STATUS: prdata_o = APB_DW'(count_q);
            default:   pslverr_o = apb_access;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= event_data_i;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Fill count matches the pointer distance, so a full FIFO is never written over
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_ptr_q == rd_ptr_q + EU_PTR_W'(count_q));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= EU_CNT_W'(EU_DEPTH));

endmodule

// File: design/fc_irq_pkg.sv
// Interrupt subsystem package
// Widths, sizes and register offset codes shared by the event unit,
// the APB register bridge and the core-local interrupt controller

package fc_irq_pkg;

    //******************************
    // Sizes and widths
    //******************************
    localparam int unsigned N_SRC         = 16;
    localparam int unsigned SRC_ID_W      = 4;
    localparam int unsigned LEVEL_W       = 8;
    localparam int unsigned EVENT_ID_W    = 8;
    localparam int unsigned EU_DEPTH      = 4;
    localparam int unsigned EU_PTR_W      = $clog2(EU_DEPTH);
    localparam int unsigned EU_CNT_W      = $clog2(EU_DEPTH + 1);
    localparam int unsigned SOC_EVENT_SRC = 10;
    localparam int unsigned APB_AW        = 12;
    localparam int unsigned APB_DW        = 32;

    // Source configuration word fields
    localparam int unsigned CFG_EN_BIT   = 0;
    localparam int unsigned CFG_MODE_BIT = 1;
    localparam int unsigned CFG_LVL_LSB  = 8;
    localparam int unsigned CFG_PEND_BIT = 16;

    localparam logic [APB_AW-1:0] CLIC_THRESH_OFFS = 12'h100;

    //******************************
    // Register offsets
    //******************************
    typedef enum logic [APB_AW-1:0] {
        EU_DATA   = 12'h000,
        EU_STATUS = 12'h004
    } eu_reg_e;

    // CLIC access kinds, resolved from the address
    typedef enum logic [1:0] {
        CLIC_SRC_CFG,
        CLIC_THRESH,
        CLIC_UNMAPPED
    } clic_reg_e;

endpackage
